//--- flist.f
dmr_pkg.sv
mac_core.sv
dmr_checker.sv
dmr_regs.sv
dmr_core_wrap.sv
dmr_core_wrap_props.sv
tb_dmr_core_wrap.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the DMR wrapper testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f flist.f \
  --top-module tb_dmr_core_wrap \
  -o sim_tb

output="$(./obj_dir/sim_tb 2>&1)"
echo "$output"

if grep -qx "TEST PASS" <<< "$output"; then
  exit 0
fi
exit 1

//--- tb_dmr_core_wrap.sv
// Directed testbench for the DMR MAC wrapper
// Inputs change 1 time unit after the rising edge, outputs are sampled there too
// Faults are injected by forcing the output bundle of core 1 for one cycle
module tb_dmr_core_wrap import dmr_pkg::*; ();

  localparam int CLK_PERIOD    = 4;
  localparam int RESET_CYCLES  = 5;
  localparam int ARITH_OPS     = 20;
  // Rough cycle cost of each test in turn
  localparam int TEST_CYCLES   = RESET_CYCLES + 4 + (ARITH_OPS + 2) + 10 + 10 + 8;
  localparam int MARGIN_CYCLES = 50;

  logic      clk;
  logic      rst_n;
  core_in_t  core_in;
  core_out_t sys_out;
  reg_req_t  reg_req;
  reg_rsp_t  reg_rsp;
  logic      dmr_error;
  logic      dmr_failure;
  core_out_t fault_out;

  integer    seed;
  int        errors;
  int        checks;
  int        tests_run;
  int        tests_failed;
  acc_t      model_acc;
  // Expected error counter value
  reg_data_t model_err_cnt;

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  dmr_core_wrap dut_i (
    .clk_i         ( clk         ),
    .rst_n_i       ( rst_n       ),
    .core_in_i     ( core_in     ),
    .sys_out_o     ( sys_out     ),
    .reg_req_i     ( reg_req     ),
    .reg_rsp_o     ( reg_rsp     ),
    .dmr_error_o   ( dmr_error   ),
    .dmr_failure_o ( dmr_failure )
  );

  task automatic check(input string test, input string what,
                       input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("mismatch %s (%s): expected %h, actual %h", test, what, expected, actual);
    end
  endtask

  task automatic finish_test(input string test, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("%s: passed", test);
    end else begin
      tests_failed++;
      $display("%s: failed", test);
    end
  endtask

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  function automatic operand_t rand_operand();
    logic [31:0] r;
    r = $random(seed);
    return r[15:0];
  endfunction

  // Expected accumulator after one valid input
  function automatic acc_t model_next(acc_t acc, mac_op_e op, operand_t a, operand_t b);
    acc_t prod;
    prod = {16'h0, a} * {16'h0, b};
    case (op)
      MAC_ACC:  return acc + prod;
      MAC_LOAD: return prod;
      MAC_CLR:  return '0;
      default:  return acc;
    endcase
  endfunction

  task automatic drive_op(input mac_op_e op, input operand_t a, input operand_t b);
    core_in.valid = 1'b1;
    core_in.op    = op;
    core_in.a     = a;
    core_in.b     = b;
    model_acc     = model_next(model_acc, op, a, b);
  endtask

  task automatic drive_idle();
    core_in = '0;
  endtask

  task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
    reg_req.valid = 1'b1;
    reg_req.write = 1'b1;
    reg_req.addr  = addr;
    reg_req.wdata = data;
    step();
    reg_req = '0;
  endtask

  task automatic reg_read(input reg_addr_t addr, output reg_data_t data, output logic err);
    reg_req.valid = 1'b1;
    reg_req.write = 1'b0;
    reg_req.addr  = addr;
    reg_req.wdata = '0;
    #1;
    data = reg_rsp.rdata;
    err  = reg_rsp.error;
    step();
    reg_req = '0;
  endtask

  // Corrupts core 1 for the cycle its result is visible, ends one edge later
  task automatic fault_cycle(input acc_t good, output core_out_t seen);
    fault_out.valid  = 1'b1;
    fault_out.result = good ^ 32'h0000_0001;
    force dut_i.i_core1.core_out_o = fault_out;
    #1;
    seen = sys_out;
    step();
    release dut_i.i_core1.core_out_o;
  endtask

  task automatic test_reset();
    int        e0;
    reg_data_t data;
    logic      err;
    e0 = errors;
    check("reset", "sys_out.valid", 32'd0, 32'(sys_out.valid));
    check("reset", "dmr_error", 32'd0, 32'(dmr_error));
    check("reset", "dmr_failure", 32'd0, 32'(dmr_failure));
    reg_read(REG_CTRL, data, err);
    check("reset", "REG_CTRL", 32'd1, data);
    reg_read(REG_ERR_CNT, data, err);
    check("reset", "REG_ERR_CNT", 32'd0, data);
    finish_test("reset", e0);
  endtask

  task automatic test_lockstep();
    int          e0;
    logic [31:0] r;
    e0 = errors;
    for (int i = 0; i < ARITH_OPS; i++) begin
      r = $random(seed);
      drive_op(mac_op_e'(r[1:0]), rand_operand(), rand_operand());
      step();
      check("lockstep", "valid", 32'd1, 32'(sys_out.valid));
      check("lockstep", "result", model_acc, sys_out.result);
      check("lockstep", "dmr_error", 32'd0, 32'(dmr_error));
    end
    drive_idle();
    step();
    check("lockstep", "idle valid", 32'd0, 32'(sys_out.valid));
    finish_test("lockstep", e0);
  endtask

  task automatic test_fault_detect();
    int        e0;
    reg_data_t data;
    logic      err;
    core_out_t seen;
    e0 = errors;
    drive_op(MAC_LOAD, rand_operand(), rand_operand());
    step();
    drive_idle();
    fault_cycle(model_acc, seen);
    check("fault_detect", "blocked valid", 32'd0, 32'(seen.valid));
    check("fault_detect", "error pulse", 32'd1, 32'(dmr_error));
    // One error pulse counted
    model_err_cnt = model_err_cnt + 32'd1;
    // Setback clears both accumulators at the end of the pulse
    model_acc = '0;
    step();
    check("fault_detect", "pulse end", 32'd0, 32'(dmr_error));
    check("fault_detect", "dmr_failure", 32'd1, 32'(dmr_failure));
    reg_read(REG_ERR_CNT, data, err);
    check("fault_detect", "REG_ERR_CNT", model_err_cnt, data);
    reg_read(REG_STATUS, data, err);
    check("fault_detect", "REG_STATUS", 32'd1, data);
    drive_op(MAC_ACC, rand_operand(), rand_operand());
    step();
    drive_idle();
    check("fault_detect", "acc valid", 32'd1, 32'(sys_out.valid));
    check("fault_detect", "acc after setback", model_acc, sys_out.result);
    finish_test("fault_detect", e0);
  endtask

  task automatic test_dmr_disabled();
    int        e0;
    reg_data_t data;
    logic      err;
    core_out_t seen;
    e0 = errors;
    reg_write(REG_CTRL, 32'd0);
    drive_op(MAC_LOAD, rand_operand(), rand_operand());
    step();
    drive_idle();
    fault_cycle(model_acc, seen);
    check("dmr_disabled", "valid", 32'd1, 32'(seen.valid));
    check("dmr_disabled", "core 0 result", model_acc, seen.result);
    check("dmr_disabled", "dmr_error", 32'd0, 32'(dmr_error));
    step();
    check("dmr_disabled", "dmr_error later", 32'd0, 32'(dmr_error));
    reg_read(REG_ERR_CNT, data, err);
    check("dmr_disabled", "REG_ERR_CNT", model_err_cnt, data);
    reg_read(REG_CTRL, data, err);
    check("dmr_disabled", "REG_CTRL", 32'd0, data);
    reg_write(REG_CTRL, 32'd1);
    finish_test("dmr_disabled", e0);
  endtask

  task automatic test_reg_access();
    int        e0;
    reg_data_t data;
    logic      err;
    e0 = errors;
    reg_write(REG_ERR_CNT, 32'hFFFF_FFFF);
    model_err_cnt = '0;
    reg_read(REG_ERR_CNT, data, err);
    check("reg_access", "REG_ERR_CNT cleared", model_err_cnt, data);
    check("reg_access", "failure before clear", 32'd1, 32'(dmr_failure));
    reg_write(REG_STATUS, 32'd1);
    check("reg_access", "failure after clear", 32'd0, 32'(dmr_failure));
    reg_read(REG_STATUS, data, err);
    check("reg_access", "REG_STATUS", 32'd0, data);
    reg_read(4'd7, data, err);
    check("reg_access", "unmapped rdata", 32'hBADCAB1E, data);
    check("reg_access", "unmapped error", 32'd1, 32'(err));
    reg_read(REG_CTRL, data, err);
    check("reg_access", "REG_CTRL", 32'd1, data);
    check("reg_access", "REG_CTRL error", 32'd0, 32'(err));
    finish_test("reg_access", e0);
  endtask

  // Watchdog
  initial begin
    #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("watchdog expired before the tests finished");
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    seed          = 32'hf2c3;
    errors        = 0;
    checks        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    model_acc     = '0;
    model_err_cnt = '0;
    fault_out     = '0;
    rst_n         = 1'b0;
    core_in       = '0;
    reg_req       = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;

    test_reset();
    test_lockstep();
    test_fault_detect();
    test_dmr_disabled();
    test_reg_access();

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- dmr_core_wrap_props.sv
// Lockstep checker properties, bound into every dmr_checker instance
// Assertions are disabled while reset is low
module dmr_checker_props import dmr_pkg::*; (
  input logic      clk_i,
  input logic      rst_n_i,
  input logic      dmr_en_i,
  input core_out_t core0_out_i,
  input core_out_t core1_out_i,
  input core_out_t sys_out_o,
  input logic      setback_o,
  input logic      dmr_error_o
);

  logic mism;

  // Same compare as the checker applies
  assign mism = dmr_en_i && (core0_out_i != core1_out_i);

  // Setback is the error pulse, one cycle behind the compare
  setback_is_error_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (setback_o == dmr_error_o) && (dmr_error_o == $past(mism)))
    else $error("setback or error pulse out of step with the mismatch");

  // A disputed result must never reach the system
  no_valid_on_mismatch_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mism |-> !sys_out_o.valid)
    else $error("system output valid during a mismatch");

  error_needs_mismatch_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dmr_error_o |=> (!dmr_error_o || $past(mism)))
    else $error("error pulse held without a new mismatch");

endmodule

bind dmr_checker dmr_checker_props i_props (
  .clk_i       ( clk_i       ),
  .rst_n_i     ( rst_n_i     ),
  .dmr_en_i    ( dmr_en_i    ),
  .core0_out_i ( core0_out_i ),
  .core1_out_i ( core1_out_i ),
  .sys_out_o   ( sys_out_o   ),
  .setback_o   ( setback_o   ),
  .dmr_error_o ( dmr_error_o )
);

//--- dmr_core_wrap.sv
// DMR wrapper with two lockstep MAC cores, a checker and a register block
// Valid levels only, there is no back-pressure on any path
// Input to sys_out_o takes one cycle, the error pulse follows one cycle later
module dmr_core_wrap import dmr_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  core_in_t  core_in_i,
  output core_out_t sys_out_o,
  input  reg_req_t  reg_req_i,
  output reg_rsp_t  reg_rsp_o,
  output logic      dmr_error_o,
  output logic      dmr_failure_o
);

  core_out_t core0_out;
  core_out_t core1_out;
  logic      setback;
  logic      dmr_error;
  logic      dmr_en;

  // Both replicas see the very same input
  mac_core i_core0 (
    .clk_i      ( clk_i     ),
    .rst_n_i    ( rst_n_i   ),
    .clear_i    ( setback   ),
    .core_in_i  ( core_in_i ),
    .core_out_o ( core0_out )
  );

  mac_core i_core1 (
    .clk_i      ( clk_i     ),
    .rst_n_i    ( rst_n_i   ),
    .clear_i    ( setback   ),
    .core_in_i  ( core_in_i ),
    .core_out_o ( core1_out )
  );

  dmr_checker i_checker (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .dmr_en_i    ( dmr_en    ),
    .core0_out_i ( core0_out ),
    .core1_out_i ( core1_out ),
    .sys_out_o   ( sys_out_o ),
    .setback_o   ( setback   ),
    .dmr_error_o ( dmr_error )
  );

  dmr_regs i_regs (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .reg_req_i     ( reg_req_i     ),
    .reg_rsp_o     ( reg_rsp_o     ),
    .dmr_error_i   ( dmr_error     ),
    .dmr_en_o      ( dmr_en        ),
    .dmr_failure_o ( dmr_failure_o )
  );

  assign dmr_error_o = dmr_error;

endmodule

//--- dmr_regs.sv
// Software view of the DMR unit
// Reads answer combinationally while the request is valid
// Error counter saturates, a clearing write beats a same-cycle error
// Unmapped addresses return REG_ERR_VAL with the error bit set
module dmr_regs import dmr_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  reg_req_t reg_req_i,
  output reg_rsp_t reg_rsp_o,
  input  logic     dmr_error_i,
  output logic     dmr_en_o,
  output logic     dmr_failure_o
);

  logic      wr_en;
  logic      dmr_en_q;
  logic      failure_q;
  reg_data_t err_cnt_q;

  assign wr_en = reg_req_i.valid && reg_req_i.write;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      // Lockstep checking is on out of reset
      dmr_en_q  <= 1'b1;
      failure_q <= 1'b0;
      err_cnt_q <= '0;
    end else begin
      if (dmr_error_i) begin
        failure_q <= 1'b1;
        if (err_cnt_q != '1) begin
          err_cnt_q <= err_cnt_q + 1'b1;
        end
      end
      // Software writes come last so they win
      if (wr_en && reg_req_i.addr == REG_CTRL) begin
        dmr_en_q <= reg_req_i.wdata[0];
      end
      if (wr_en && reg_req_i.addr == REG_ERR_CNT) begin
        err_cnt_q <= '0;
      end
      if (wr_en && reg_req_i.addr == REG_STATUS && reg_req_i.wdata[0]) begin
        failure_q <= 1'b0;
      end
    end
  end

  always_comb begin
    reg_rsp_o = '0;
    if (reg_req_i.valid) begin
      case (reg_req_i.addr)
        REG_CTRL: begin
          reg_rsp_o.rdata = reg_data_t'(dmr_en_q);
        end
        REG_ERR_CNT: begin
          reg_rsp_o.rdata = err_cnt_q;
        end
        REG_STATUS: begin
          reg_rsp_o.rdata = reg_data_t'(failure_q);
        end
        default: begin
          reg_rsp_o.rdata = REG_ERR_VAL;
          reg_rsp_o.error = 1'b1;
        end
      endcase
    end
  end

  assign dmr_en_o      = dmr_en_q;
  assign dmr_failure_o = failure_q;

endmodule

//--- dmr_checker.sv
// Lockstep comparator for two replicas
// Core 0 is the one whose result reaches the system
// dmr_error_o and setback_o are the same one-cycle registered pulse
module dmr_checker import dmr_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      dmr_en_i,
  input  core_out_t core0_out_i,
  input  core_out_t core1_out_i,
  output core_out_t sys_out_o,
  output logic      setback_o,
  output logic      dmr_error_o
);

  logic mismatch;
  logic error_q;

  // Bit-for-bit compare of the whole output bundle
  assign mismatch = dmr_en_i && (core0_out_i != core1_out_i);

  // Pass core 0 through, but never let a disputed result out
  always_comb begin
    sys_out_o = core0_out_i;
    if (mismatch) begin
      sys_out_o.valid = 1'b0;
    end
  end

  // Error pulse lands in the cycle after the mismatch
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      error_q <= 1'b0;
    end else begin
      error_q <= mismatch;
    end
  end

  assign dmr_error_o = error_q;

  // Both cores clear at the edge that ends the error pulse
  assign setback_o = error_q;

endmodule

//--- mac_core.sv
// One multiply-accumulate replica with a single cycle of latency
// Product is unsigned 16x16, accumulation wraps at 32 bits
// clear_i is synchronous and overrides any input in the same cycle
module mac_core import dmr_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      clear_i,
  input  core_in_t  core_in_i,
  output core_out_t core_out_o
);

  acc_t acc_q;
  acc_t acc_d;
  acc_t product;
  logic valid_q;
  logic valid_d;

  // Full-width product so nothing is lost before the add
  assign product = acc_t'(core_in_i.a) * acc_t'(core_in_i.b);

  always_comb begin
    acc_d   = acc_q;
    valid_d = 1'b0;
    if (clear_i) begin
      // Setback from the checker realigns both replicas
      acc_d = '0;
    end else if (core_in_i.valid) begin
      valid_d = 1'b1;
      case (core_in_i.op)
        MAC_ACC: begin
          acc_d = acc_q + product;
        end
        MAC_LOAD: begin
          acc_d = product;
        end
        MAC_CLR: begin
          acc_d = '0;
        end
        default: begin
          // NOP still answers with the current value
          acc_d = acc_q;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      acc_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      acc_q   <= acc_d;
      valid_q <= valid_d;
    end
  end

  // The accumulator register is the result register
  assign core_out_o.valid  = valid_q;
  assign core_out_o.result = acc_q;

endmodule

//--- dmr_pkg.sv
// Types and constants shared by the DMR MAC wrapper and its testbench
// Operands are unsigned and the accumulator wraps at 32 bits
// Register addresses are word addresses
package dmr_pkg;

  // Datapath widths
  localparam int unsigned OPERAND_W  = 16;
  localparam int unsigned ACC_W      = 32;

  // Register interface widths
  localparam int unsigned REG_ADDR_W = 4;
  localparam int unsigned REG_DATA_W = 32;

  typedef logic [OPERAND_W-1:0]  operand_t;
  typedef logic [ACC_W-1:0]      acc_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [REG_DATA_W-1:0] reg_data_t;

  // MAC operation encoding
  typedef enum logic [1:0] {
    MAC_NOP  = 2'd0,
    MAC_ACC  = 2'd1,
    MAC_LOAD = 2'd2,
    MAC_CLR  = 2'd3
  } mac_op_e;

  // Input bundle fanned out to both replicas
  typedef struct packed {
    logic     valid;
    mac_op_e  op;
    operand_t a;
    operand_t b;
  } core_in_t;

  // Output bundle compared by the checker
  typedef struct packed {
    logic valid;
    acc_t result;
  } core_out_t;

  typedef struct packed {
    logic      valid;
    logic      write;
    reg_addr_t addr;
    reg_data_t wdata;
  } reg_req_t;

  typedef struct packed {
    reg_data_t rdata;
    logic      error;
  } reg_rsp_t;

  // Register map
  localparam reg_addr_t REG_CTRL    = 4'd0;
  localparam reg_addr_t REG_ERR_CNT = 4'd1;
  localparam reg_addr_t REG_STATUS  = 4'd2;

  // Read data for unmapped addresses
  localparam reg_data_t REG_ERR_VAL = 32'hBADCAB1E;

endpackage
